// File: hdl/mipsIsaPkg.sv
package mipsIsaPkg;
	localparam int dataWidth = 32; // Machine word

	typedef logic [4:0] regIdxT; // Register number
	typedef logic [5:0] opcodeT; // Primary opcode, bits 31:26
	typedef logic [5:0] functT;  // R-type function, bits 5:0

	localparam opcodeT opRType = 6'h00;
	localparam opcodeT opBeq   = 6'h04;
	localparam opcodeT opBlez  = 6'h06;
	localparam opcodeT opBgtz  = 6'h07;
	localparam opcodeT opAddi  = 6'h08;
	localparam opcodeT opAddiu = 6'h09;
	localparam opcodeT opSlti  = 6'h0a;
	localparam opcodeT opSltiu = 6'h0b;
	localparam opcodeT opAndi  = 6'h0c;
	localparam opcodeT opOri   = 6'h0d;
	localparam opcodeT opXori  = 6'h0e;
	localparam opcodeT opLui   = 6'h0f;
	localparam opcodeT opLw    = 6'h23;
	localparam opcodeT opSw    = 6'h2b;

	localparam functT fnSllv = 6'h04; // Variable shifts
	localparam functT fnSrlv = 6'h06;
	localparam functT fnSrav = 6'h07;
	localparam functT fnAdd  = 6'h20;
	localparam functT fnAddu = 6'h21;
	localparam functT fnSub  = 6'h22;
	localparam functT fnSubu = 6'h23;
	localparam functT fnAnd  = 6'h24;
	localparam functT fnOr   = 6'h25;
	localparam functT fnXor  = 6'h26;
	localparam functT fnNor  = 6'h27;
	localparam functT fnSlt  = 6'h2a;
	localparam functT fnSltu = 6'h2b;

	typedef struct packed {
		regIdxT rd;
		logic [4:0] shamt;
		functT funct;
	} rFieldsT; // Low half seen as R-type fields

	typedef union packed {
		rFieldsT r;
		logic [15:0] imm; // I-type view of the same bits
	} lowFieldsT;

	typedef struct packed {
		opcodeT opcode;
		regIdxT rs;
		regIdxT rt;
		lowFieldsT tail;
	} instrT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
	} aluOpT;

	typedef struct packed {
		logic known; // Encoding is in the kept subset
		aluOpT op;
	} aluSelT;

	function automatic aluSelT functToAlu(functT funct);
		aluSelT sel;
		sel = '{known: 1'b1, op: aluAdd};
		case (funct)
			fnAdd, fnAddu: sel.op = aluAdd; // No overflow trap
			fnSub, fnSubu: sel.op = aluSub;
			fnAnd: sel.op = aluAnd;
			fnOr: sel.op = aluOr;
			fnXor: sel.op = aluXor;
			fnNor: sel.op = aluNor;
			fnSlt: sel.op = aluSlt;
			fnSltu: sel.op = aluSltu;
			fnSllv: sel.op = aluSll;
			fnSrlv: sel.op = aluSrl;
			fnSrav: sel.op = aluSra;
			default: sel.known = 1'b0; // Unknown funct acts as nop
		endcase
		return sel;
	endfunction

	function automatic aluSelT opcodeToAlu(opcodeT opcode);
		aluSelT sel;
		sel = '{known: 1'b1, op: aluAdd};
		case (opcode)
			opAddi, opAddiu, opLw, opSw: sel.op = aluAdd; // Loads and stores add base and offset
			opSlti: sel.op = aluSlt;
			opSltiu: sel.op = aluSltu;
			opAndi: sel.op = aluAnd;
			opOri: sel.op = aluOr;
			opXori: sel.op = aluXor;
			opLui: sel.op = aluLui;
			default: sel.known = 1'b0;
		endcase
		return sel;
	endfunction
endpackage

// File: hdl/mipsCtrlPkg.sv
package mipsCtrlPkg;
	localparam int reqAddrWidth = 12; // Byte address bits on the memory port

	typedef enum logic [3:0] {
		fetch,     // Wait for instruction transfer
		decode,    // Opcode dispatch
		execute,   // ALU op and writeback
		memAddr,   // Effective address, launch data request
		memAccess, // Wait for data transfer
		loadWrite, // Load data to rt
		branch     // Condition and target
	} fsmStateT;

	typedef struct packed {
		logic irLoad;     // Request is an instruction fetch
		logic pcLoad;     // Update pc this edge
		logic regWrite;
		logic regDstRd;   // rd, else rt
		logic memToReg;   // Write load data, else ALU result
		logic aluSrcImm;  // Second operand from immediate
		logic immZeroExt; // Logical immediates
		logic useFunct;   // ALU op from funct, else from opcode
		logic memStart;   // Launch a memory request
		logic memWrite;
		logic branchEval; // pc takes target if condition holds
	} ctrlWordT;

	typedef struct packed {
		logic [reqAddrWidth-1:0] addr;
		logic [mipsIsaPkg::dataWidth-1:0] wData;
		logic write;
	} memReqT;
endpackage

// File: hdl/controlFsm.sv
`timescale 1ns/1ps

module controlFsm (
	input logic CLK,
	input logic reset,
	input mipsIsaPkg::instrT instr,
	input logic memDone,
	output mipsCtrlPkg::ctrlWordT ctrl
);
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	fsmStateT state;
	fsmStateT nextState;
	logic fetchIssued; // Fetch already launched by execute or branch
	logic isRType;
	logic isZeroExtOp;
	aluSelT functSel;
	aluSelT opcodeSel;

	assign isRType = (instr.opcode == opRType);
	assign isZeroExtOp = (instr.opcode == opAndi) || (instr.opcode == opOri) ||
		(instr.opcode == opXori); // Logical immediates zero-extend
	assign functSel = functToAlu(instr.tail.r.funct);
	assign opcodeSel = opcodeToAlu(instr.opcode);

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= fetch;
			fetchIssued <= 1'b0; // First fetch issues itself
		end else begin
			state <= nextState;
			if (ctrl.memStart && ctrl.irLoad) begin
				fetchIssued <= 1'b1;
			end else if (state == fetch && memDone) begin
				fetchIssued <= 1'b0; // Instruction arrived
			end
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			fetch: if (memDone) nextState = decode;
			decode: begin
				case (instr.opcode)
					opLw, opSw: nextState = memAddr;
					opBeq, opBgtz, opBlez: nextState = branch;
					default: nextState = execute; // ALU ops, unknown ones run as nop
				endcase
			end
			execute: nextState = fetch;
			branch: nextState = fetch;
			memAddr: nextState = memAccess;
			memAccess: begin
				if (memDone) begin
					nextState = (instr.opcode == opLw) ? loadWrite : fetch;
				end
			end
			loadWrite: nextState = fetch;
			default: nextState = fetch;
		endcase
	end

	always_comb begin
		ctrl = '0;
		case (state)
			fetch: begin
				ctrl.memStart = !fetchIssued; // After reset or a memory instruction
				ctrl.irLoad = !fetchIssued;
			end
			execute: begin
				ctrl.useFunct = isRType;
				ctrl.regDstRd = isRType;
				ctrl.aluSrcImm = !isRType;
				ctrl.immZeroExt = isZeroExtOp;
				ctrl.regWrite = isRType ? functSel.known : opcodeSel.known;
				ctrl.pcLoad = 1'b1;   // pc + 4
				ctrl.memStart = 1'b1; // Next fetch goes out with the new pc
				ctrl.irLoad = 1'b1;
			end
			branch: begin
				ctrl.branchEval = 1'b1;
				ctrl.pcLoad = 1'b1;
				ctrl.memStart = 1'b1;
				ctrl.irLoad = 1'b1;
			end
			memAddr: begin
				ctrl.aluSrcImm = 1'b1; // Base plus signed offset
				ctrl.memStart = 1'b1;
				ctrl.memWrite = (instr.opcode == opSw);
			end
			memAccess: ctrl.pcLoad = memDone; // Advance once data moved
			loadWrite: begin
				ctrl.regWrite = 1'b1; // Into rt
				ctrl.memToReg = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end
endmodule

// File: hdl/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic CLK,
	input logic reset,
	input mipsIsaPkg::instrT instr,
	input mipsCtrlPkg::ctrlWordT ctrl,
	input logic [mipsIsaPkg::dataWidth-1:0] aluResult,
	input logic [mipsIsaPkg::dataWidth-1:0] loadData,
	output logic [mipsIsaPkg::dataWidth-1:0] rsData,
	output logic [mipsIsaPkg::dataWidth-1:0] rtData
);
	import mipsIsaPkg::*;

	logic [dataWidth-1:0] regs [32];
	regIdxT dest;
	logic [dataWidth-1:0] wData;

	assign dest = ctrl.regDstRd ? instr.tail.r.rd : instr.rt;
	assign wData = ctrl.memToReg ? loadData : aluResult;

	assign rsData = (instr.rs == '0) ? '0 : regs[instr.rs]; // r0 reads zero
	assign rtData = (instr.rt == '0) ? '0 : regs[instr.rt];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.regWrite && dest != '0) begin
			regs[dest] <= wData; // Visible next cycle
		end
	end
endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
	input mipsIsaPkg::instrT instr,
	input mipsCtrlPkg::ctrlWordT ctrl,
	input logic [mipsIsaPkg::dataWidth-1:0] rsData,
	input logic [mipsIsaPkg::dataWidth-1:0] rtData,
	output logic [mipsIsaPkg::dataWidth-1:0] aluResult
);
	import mipsIsaPkg::*;

	logic [dataWidth-1:0] immExt;
	logic [dataWidth-1:0] opB;
	logic [4:0] shiftAmt;
	aluSelT sel;

	assign immExt = ctrl.immZeroExt ? {16'b0, instr.tail.imm} :
		{{16{instr.tail.imm[15]}}, instr.tail.imm};
	assign opB = ctrl.aluSrcImm ? immExt : rtData;
	assign shiftAmt = rsData[4:0]; // Variable shift count from rs
	assign sel = ctrl.useFunct ? functToAlu(instr.tail.r.funct) : opcodeToAlu(instr.opcode);

	always_comb begin
		if (!sel.known) begin
			aluResult = '0;
		end else begin
			case (sel.op)
				aluAdd: aluResult = rsData + opB;
				aluSub: aluResult = rsData - opB;
				aluAnd: aluResult = rsData & opB;
				aluOr: aluResult = rsData | opB;
				aluXor: aluResult = rsData ^ opB;
				aluNor: aluResult = ~(rsData | opB);
				aluSlt: aluResult = dataWidth'($signed(rsData) < $signed(opB));
				aluSltu: aluResult = dataWidth'(rsData < opB); // sltiu compares the sign-extended imm
				aluSll: aluResult = rtData << shiftAmt;
				aluSrl: aluResult = rtData >> shiftAmt;
				aluSra: aluResult = $signed(rtData) >>> shiftAmt;
				aluLui: aluResult = {instr.tail.imm, 16'b0}; // Upper half
				default: aluResult = '0;
			endcase
		end
	end
endmodule

// File: hdl/pcUnit.sv
`timescale 1ns/1ps

module pcUnit #(
	parameter int addrWidth = mipsCtrlPkg::reqAddrWidth
) (
	input logic CLK,
	input logic reset,
	input mipsIsaPkg::instrT instr,
	input mipsCtrlPkg::ctrlWordT ctrl,
	input logic [mipsIsaPkg::dataWidth-1:0] rsData,
	input logic [mipsIsaPkg::dataWidth-1:0] rtData,
	output logic [addrWidth-1:0] pc
);
	import mipsIsaPkg::*;

	logic [addrWidth-1:0] pcPlus4;
	logic [addrWidth-1:0] offset;
	logic [addrWidth-1:0] branchTarget;
	logic taken;

	assign pcPlus4 = pc + addrWidth'(4);
	assign offset = addrWidth'({{14{instr.tail.imm[15]}}, instr.tail.imm, 2'b00}); // Word offset
	assign branchTarget = pcPlus4 + offset; // No delay slot

	always_comb begin
		case (instr.opcode)
			opBeq: taken = (rsData == rtData);
			opBgtz: taken = ($signed(rsData) > 32'sd0);
			opBlez: taken = ($signed(rsData) <= 32'sd0);
			default: taken = 1'b0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
		end else if (ctrl.pcLoad) begin
			pc <= (ctrl.branchEval && taken) ? branchTarget : pcPlus4;
		end
	end
endmodule

// File: hdl/memPort.sv
`timescale 1ns/1ps

module memPort #(
	parameter int addrWidth = mipsCtrlPkg::reqAddrWidth
) (
	input logic CLK,
	input logic reset,
	input mipsCtrlPkg::ctrlWordT ctrl,
	input logic [addrWidth-1:0] pc,
	input logic [mipsIsaPkg::dataWidth-1:0] aluResult,
	input logic [mipsIsaPkg::dataWidth-1:0] rtData,
	input logic memReady,
	input logic [mipsIsaPkg::dataWidth-1:0] memRData,
	output logic memReqValid,
	output mipsCtrlPkg::memReqT memReq,
	output mipsIsaPkg::instrT instr,
	output logic [mipsIsaPkg::dataWidth-1:0] loadData,
	output logic memDone
);
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	logic reqIsFetch;              // Pending request targets the IR
	logic reqWrite;
	logic [addrWidth-1:0] dataAddr;
	logic [dataWidth-1:0] storeData;
	logic [addrWidth-1:0] reqAddr;

	assign memDone = memReqValid && memReady; // Transfer edge

	// pc holds still while a fetch is pending
	assign reqAddr = reqIsFetch ? pc : dataAddr;
	assign memReq = '{addr: reqAddrWidth'(reqAddr), wData: storeData, write: reqWrite};

	always_ff @(posedge CLK) begin
		if (reset) begin
			memReqValid <= 1'b0;
			reqIsFetch <= 1'b0;
			reqWrite <= 1'b0;
			instr <= '0;
		end else begin
			if (ctrl.memStart) begin
				memReqValid <= 1'b1; // Up until accepted
				reqIsFetch <= ctrl.irLoad;
				reqWrite <= ctrl.memWrite;
			end else if (memDone) begin
				memReqValid <= 1'b0;
			end
			if (memDone && reqIsFetch) begin
				instr <= instrT'(memRData);
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (ctrl.memStart && !ctrl.irLoad) begin
			dataAddr <= aluResult[addrWidth-1:0]; // Byte address
			storeData <= rtData;
		end
		if (memDone && !reqIsFetch) begin
			loadData <= memRData; // Write data is echoed on a store and ignored
		end
	end
endmodule

// File: hdl/mipsCore.sv
`timescale 1ns/1ps

module mipsCore #(
	parameter int addrWidth = mipsCtrlPkg::reqAddrWidth
) (
	input logic CLK,
	input logic reset,
	output logic memReqValid,
	output mipsCtrlPkg::memReqT memReq,
	input logic memReady,
	input logic [mipsIsaPkg::dataWidth-1:0] memRData
);
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	ctrlWordT ctrl;               // Control word of the current state
	instrT instr;                 // Instruction register
	logic memDone;                // Transfer this cycle
	logic [dataWidth-1:0] rsData;
	logic [dataWidth-1:0] rtData;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] loadData;
	logic [addrWidth-1:0] pc;

	controlFsm uCtrl (
		.CLK(CLK),
		.reset(reset),
		.instr(instr),
		.memDone(memDone),
		.ctrl(ctrl)
	);

	regFile uRegs (
		.CLK(CLK),
		.reset(reset),
		.instr(instr),
		.ctrl(ctrl),
		.aluResult(aluResult),
		.loadData(loadData),
		.rsData(rsData),
		.rtData(rtData)
	);

	alu uAlu (
		.instr(instr),
		.ctrl(ctrl),
		.rsData(rsData),
		.rtData(rtData),
		.aluResult(aluResult)
	);

	pcUnit #(.addrWidth(addrWidth)) uPc (
		.CLK(CLK),
		.reset(reset),
		.instr(instr),
		.ctrl(ctrl),
		.rsData(rsData),
		.rtData(rtData),
		.pc(pc)
	);

	memPort #(.addrWidth(addrWidth)) uMem (
		.CLK(CLK),
		.reset(reset),
		.ctrl(ctrl),
		.pc(pc),
		.aluResult(aluResult),  // Data address
		.rtData(rtData),        // Store data
		.memReady(memReady),
		.memRData(memRData),
		.memReqValid(memReqValid),
		.memReq(memReq),
		.instr(instr),
		.loadData(loadData),
		.memDone(memDone)
	);
endmodule

// File: testbench/mipsCore_sva.sv
`timescale 1ns/1ps

module mipsCoreSva (
	input logic CLK,
	input logic reset,
	input logic memReqValid,
	input mipsCtrlPkg::memReqT memReq,
	input logic memReady,
	input logic isFetch
);
	int failCount = 0; // Summed into the testbench totals

	noReqInReset: assert property (@(posedge CLK) reset |=> !memReqValid)
		else begin
			$error("memory request raised during or right after reset");
			failCount++;
		end

	reqHeld: assert property (@(posedge CLK) disable iff (reset)
		memReqValid && !memReady |=> memReqValid && $stable(memReq))
		else begin
			$error("memory request changed or dropped before ready");
			failCount++;
		end

	fetchAligned: assert property (@(posedge CLK) disable iff (reset)
		memReqValid && isFetch |-> memReq.addr[1:0] == 2'b00)
		else begin
			$error("fetch address not word aligned");
			failCount++;
		end
endmodule

bind mipsCore mipsCoreSva svaChecks (
	.CLK(CLK),
	.reset(reset),
	.memReqValid(memReqValid),
	.memReq(memReq),
	.memReady(memReady),
	.isFetch(uMem.reqIsFetch) // Pending request is an instruction fetch
);

// File: testbench/tbRefModel.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Instruction-level model of the kept subset, no delay slot
function automatic void runReference(int maxSteps);
	logic [31:0] regs [32];
	logic [31:0] iw;
	logic [31:0] a, b, sImm, res;
	logic [11:0] pc, lastPc, ea;
	logic [4:0] dst;
	logic wr;
	regs = '{default: '0};
	refMem = mem; // Own copy, the DUT run writes mem
	pc = '0;
	lastPc = '1;
	for (int step = 0; step < maxSteps; step++) begin
		expFetch.push_back(pc);
		if (pc == lastPc) break; // Halt branched onto itself
		lastPc = pc;
		iw = refMem[pc[11:2]];
		a = regs[iw[25:21]]; // rs
		b = regs[iw[20:16]]; // rt
		sImm = {{16{iw[15]}}, iw[15:0]};
		ea = 12'(a + sImm); // Data byte address
		dst = iw[20:16];
		wr = 1'b1;
		res = '0;
		pc = pc + 12'd4;
		case (iw[31:26])
			opRType: begin
				dst = iw[15:11];
				case (iw[5:0])
					fnAdd, fnAddu: res = a + b;
					fnSub, fnSubu: res = a - b;
					fnAnd: res = a & b;
					fnOr: res = a | b;
					fnXor: res = a ^ b;
					fnNor: res = ~(a | b);
					fnSlt: res = {31'b0, $signed(a) < $signed(b)};
					fnSltu: res = {31'b0, a < b};
					fnSllv: res = b << a[4:0]; // Shift count from rs
					fnSrlv: res = b >> a[4:0];
					fnSrav: res = $signed(b) >>> a[4:0];
					default: wr = 1'b0;
				endcase
			end
			opAddi, opAddiu: res = a + sImm;
			opSlti: res = {31'b0, $signed(a) < $signed(sImm)};
			opSltiu: res = {31'b0, a < sImm}; // Unsigned compare, sign-extended imm
			opAndi: res = a & {16'b0, iw[15:0]}; // Logical ops zero-extend
			opOri: res = a | {16'b0, iw[15:0]};
			opXori: res = a ^ {16'b0, iw[15:0]};
			opLui: res = {iw[15:0], 16'b0};
			opLw: res = refMem[ea[11:2]];
			opSw: begin
				wr = 1'b0;
				refMem[ea[11:2]] = b;
				expStoreAddr.push_back(ea);
				expStoreData.push_back(b);
			end
			opBeq, opBgtz, opBlez: begin
				wr = 1'b0;
				if ((iw[31:26] == opBeq && a == b) || (iw[31:26] == opBgtz && $signed(a) > 0) ||
					(iw[31:26] == opBlez && $signed(a) <= 0)) begin
					pc = pc + 12'(sImm << 2); // Relative to pc + 4
				end
			end
			default: wr = 1'b0; // Unknown opcode is a nop
		endcase
		if (wr && dst != 5'd0) begin
			regs[dst] = res;
		end
	end
endfunction

`endif

// File: testbench/tbMipsCore.sv
`timescale 1ns/1ps

module tbMipsCore;
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	functT fnList [13] = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt,
		fnSltu, fnSllv, fnSrlv, fnSrav};
	opcodeT immOps [8] = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};
	opcodeT brOps [3] = '{opBeq, opBgtz, opBlez};

	logic CLK = 1'b0;
	logic reset;
	logic memReady;
	logic [31:0] memRData;
	logic memReqValid;
	memReqT memReq;

	logic [31:0] mem [1024];    // Shared instruction and data memory
	logic [31:0] refMem [1024]; // Reference image
	logic [11:0] expFetch [$];
	logic [11:0] expStoreAddr [$];
	logic [31:0] expStoreData [$];
	int progLen = 0;
	int fIdx = 0;
	int stIdx = 0;
	int waitLeft;
	int errFetch = 0;
	int errStore = 0;
	int errOther = 0;
	bit done = 1'b0;

	mipsCore uut (
		.CLK(CLK),
		.reset(reset),
		.memReqValid(memReqValid),
		.memReq(memReq),
		.memReady(memReady),
		.memRData(memRData)
	);

	`include "tbRefModel.svh"

	always #20 CLK = ~CLK; // 40 ns period

	function automatic logic [31:0] randomAlu();
		regIdxT rd;
		rd = 5'($urandom_range(15, 3)); // r1 and r2 keep their signs
		if ($urandom_range(1, 0) == 1) begin
			return {opRType, 5'($urandom_range(15, 0)), 5'($urandom_range(15, 0)), rd, 5'd0,
				fnList[$urandom_range(12, 0)]};
		end
		return {immOps[$urandom_range(7, 0)], 5'($urandom_range(15, 0)), rd, 16'($urandom)};
	endfunction

	task automatic appendWord(logic [31:0] word);
		mem[progLen] = word;
		progLen++;
	endtask

	task automatic buildProgram();
		opcodeT op;
		regIdxT rt;
		logic [15:0] imm;
		for (int i = 0; i < 1024; i++) begin
			mem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f; // Fill depends on every address bit
		end
		for (int r = 1; r <= 8; r++) begin
			imm = 16'($urandom);
			imm[15] = (r == 2) ? 1'b1 : (r == 1) ? 1'b0 : imm[15]; // r1 positive, r2 negative
			appendWord({(r > 5) ? opLui : opAddi, 5'd0, 5'(r), imm});
		end
		for (int b = 0; b < 6; b++) begin
			op = (b < 2) ? opBeq : (b < 4) ? opBgtz : opBlez;
			appendWord({op, 5'(1 + b % 2), 5'd1, 16'd1}); // Each kind taken once, not taken once
			appendWord(randomAlu());
		end
		for (int k = 0; k < 20; k++) begin
			case ($urandom_range(3, 0))
				0: begin
					rt = 5'($urandom_range(15, 3));
					appendWord({opLw, 5'd0, rt, 16'(16'h800 + 4 * $urandom_range(63, 0))});
					appendWord({opSw, 5'd0, rt, 16'(16'hc00 + 4 * $urandom_range(63, 0))});
				end
				1: appendWord({brOps[$urandom_range(2, 0)], 5'($urandom_range(15, 0)),
					5'($urandom_range(15, 0)), 16'($urandom_range(2, 1))}); // Skips 1 or 2
				default: appendWord(randomAlu());
			endcase
		end
		for (int r = 0; r < 16; r++) begin
			appendWord({opSw, 5'd0, 5'(r), 16'(16'he00 + 4 * r)}); // Register dump
		end
		appendWord({opBeq, 5'd0, 5'd0, 16'hffff}); // Halt loop
	endtask

	always @(posedge CLK) begin // Memory with random wait states
		if (memReqValid && memReady && memReq.write) begin
			mem[memReq.addr[11:2]] = memReq.wData;
		end
		#2;
		memReady = 1'b0;
		if (memReqValid === 1'b1) begin
			if (waitLeft < 0) begin
				waitLeft = $urandom_range(3, 0); // New request
			end
			if (waitLeft == 0) begin
				memReady = 1'b1;
				memRData = mem[memReq.addr[11:2]]; // Valid in the transfer cycle
			end
			waitLeft--;
		end
	end

	always @(posedge CLK) begin // Checks each transfer
		if (!reset && !done && memReqValid && memReady) begin
			if (memReq.write) begin
				if (stIdx >= expStoreAddr.size()) begin
					errOther++;
					$display("%0t: store beyond the expected store sequence", $time);
				end else begin
					if (memReq.addr != expStoreAddr[stIdx]) begin
						errStore++;
						$display("ERR %0t memReq.addr expected %h actual %h", $time,
							expStoreAddr[stIdx], memReq.addr);
					end
					if (memReq.wData != expStoreData[stIdx]) begin
						errStore++;
						$display("ERR %0t memReq.wData expected %h actual %h", $time,
							expStoreData[stIdx], memReq.wData);
					end
					stIdx++;
				end
			end else if (!memReq.addr[11]) begin // Program region, so a fetch
				if (memReq.addr != expFetch[fIdx]) begin
					errFetch++;
					$display("ERR %0t memReq.addr expected %h actual %h", $time,
						expFetch[fIdx], memReq.addr);
				end
				fIdx++;
				done = (fIdx == expFetch.size()); // Halt fetched twice
			end
		end
	end

	initial begin
		reset = 1'b1;
		memReady = 1'b0;
		memRData = '0;
		waitLeft = -1;
		void'($urandom(32'hd72f_2918));
		buildProgram();
		runReference(4 * progLen);
		repeat (10) @(posedge CLK);
		#2;
		reset = 1'b0;
		wait (done);
		if (stIdx != expStoreAddr.size()) begin
			errOther++;
			$display("%0t: only %0d of %0d expected stores seen", $time, stIdx,
				expStoreAddr.size());
		end
		errOther += uut.svaChecks.failCount;
		$display("errors: fetch %0d, store %0d, other %0d", errFetch, errStore, errOther);
		if (errFetch + errStore + errOther == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin // Watchdog
		#1;
		#(progLen * 6 * 4 * 40 + 20 * 40); // Six cycles, four stalls each, plus reset
		$display("%0t: timeout, halt loop not reached", $time);
		$display("sim failed");
		$finish;
	end
endmodule

// File: flist.f
+incdir+testbench
hdl/mipsIsaPkg.sv
hdl/mipsCtrlPkg.sv
hdl/controlFsm.sv
hdl/regFile.sv
hdl/alu.sv
hdl/pcUnit.sv
hdl/memPort.sv
hdl/mipsCore.sv
testbench/mipsCore_sva.sv
testbench/tbMipsCore.sv
